/* list.f */
source/apb_pkg.sv
source/apb_access_fsm.sv
source/wait_timer.sv
source/reg_bank.sv
source/apb_protocol_monitor.sv
source/apb_regbank_top.sv
tests/tb_clock_gen.sv
tests/apb_regbank_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the APB register slave testbench with Verilator and runs it.
# The run fails if the build or the simulation fails, or if the log
# holds the fail message.

LOG=sim.log
OBJ=obj_dir
BIN=apb_regbank_sim

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module apb_regbank_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	exit 1
fi
exit 0

/* tests/apb_regbank_tb.sv */
/*
 * Testbench for the APB3 register slave with wait states.
 * Acts as the APB master, keeps a reference model of the registers and
 * checks pready timing, pslverr and the monitor flags with assertions.
 * Inputs change 5 ns after the rising edge; outputs are sampled on the
 * falling edge. One line per test, then a closing summary.
 */
`timescale 1ns/1ns
`default_nettype none

module apb_regbank_tb;

	localparam int ADDR_W       = 12;
	localparam int MAX_STALL    = 4;
	localparam int DRIVE_DELAY  = 5;
	// Longest wait for pready before a transfer is abandoned
	localparam int XFER_TIMEOUT = 16;
	localparam int unsigned RAND_SEED = 32'h8b235994;

	// Rough cycle length of each test
	localparam int LEN_RESET = 10;
	localparam int LEN_T1    = 100;
	localparam int LEN_T2    = 40;
	localparam int LEN_T3    = 50;
	localparam int LEN_T4    = 60;
	localparam int LEN_T5    = 60;
	localparam int LEN_T6    = 1400;
	localparam int WATCHDOG_CYCLES =
		2 * (LEN_RESET + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6);

	// Partial strobe pattern per data register
	localparam logic [3:0] PART_STRB [4] = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};

	logic PCLK;
	logic rst;

	// Master side of the bus
	logic                      psel;
	logic                      penable;
	logic [ADDR_W-1:0]         paddr;
	logic                      pwrite;
	logic [31:0]               pwdata;
	logic [3:0]                pwstrb;
	logic [2:0]                pprot;
	logic [31:0]               prdata;
	logic                      pready;
	logic                      pslverr;
	logic [apb_pkg::VIO_W-1:0] violations;

	// Reference model of the registers
	logic [31:0]                model_data [4];
	logic [apb_pkg::WAIT_W-1:0] model_wait;

	// Test bookkeeping
	string test_name;
	int    test_errors;
	int    total_errors;
	int    tests_run;
	int    tests_failed;
	int    cyc = 0;

	// Transfer tracking for the timing checks
	logic in_xfer;
	int   ready_cyc;
	logic exp_ready;
	logic exp_err;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4), .DRIVE_DELAY(DRIVE_DELAY)) u_clk (
		.PCLK (PCLK),
		.rst  (rst)
	);

	apb_regbank_top #(.ADDR_W(ADDR_W), .MAX_STALL(MAX_STALL)) DUT (
		.PCLK       (PCLK),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.paddr      (paddr),
		.pwrite     (pwrite),
		.pwdata     (pwdata),
		.pwstrb     (pwstrb),
		.pprot      (pprot),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.violations (violations)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [ADDR_W-1:0] data_addr(input int idx);
		case (idx)
			0:       return ADDR_W'(apb_pkg::ADDR_DATA0);
			1:       return ADDR_W'(apb_pkg::ADDR_DATA1);
			2:       return ADDR_W'(apb_pkg::ADDR_DATA2);
			default: return ADDR_W'(apb_pkg::ADDR_DATA3);
		endcase
	endfunction

	function automatic logic is_data(input logic [ADDR_W-1:0] addr);
		return addr == data_addr(0) || addr == data_addr(1)
			|| addr == data_addr(2) || addr == data_addr(3);
	endfunction

	// Error rules of the register map
	function automatic logic expect_err(input logic [ADDR_W-1:0] addr, input logic write,
		input logic [2:0] prot, input logic [3:0] strb);
		logic cfg;
		logic status;
		cfg    = (addr == ADDR_W'(apb_pkg::ADDR_WAIT_CFG));
		status = (addr == ADDR_W'(apb_pkg::ADDR_STATUS));
		if (!(is_data(addr) || cfg || status))
			return 1'b1;
		// Only the clearing write may touch status
		if (write && status && !strb[0])
			return 1'b1;
		// Config takes privileged writes only
		if (write && cfg && !prot[0])
			return 1'b1;
		return 1'b0;
	endfunction

	function automatic void model_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [2:0] prot);
		if (!expect_err(addr, 1'b1, prot, strb))
		begin
			// Byte merge under the strobes
			if (is_data(addr))
				for (int b = 0; b < 4; b++)
					if (strb[b])
						model_data[addr[3:2]][8*b +: 8] = data[8*b +: 8];
			if (addr == ADDR_W'(apb_pkg::ADDR_WAIT_CFG) && strb[0])
				model_wait = data[apb_pkg::WAIT_W-1:0];
		end
	endfunction

	function automatic logic [31:0] model_read(input logic [ADDR_W-1:0] addr);
		logic [31:0] val;
		val = '0;
		if (is_data(addr))
			val = model_data[addr[3:2]];
		else if (addr == ADDR_W'(apb_pkg::ADDR_WAIT_CFG))
			val = 32'(model_wait);
		return val;
	endfunction

	//////////////////////////////
	// Checks and reporting
	//////////////////////////////

	task automatic count_error();
		test_errors++;
		total_errors++;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Error %s: %s expected %h actual %h", test_name, what, expected, actual);
			count_error();
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0)
			$display("Test %s: ok", test_name);
		else
		begin
			$display("Test %s: FAILED with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	always @(posedge PCLK)
		cyc <= cyc + 1;

	// pready timing and pslverr qualification sampled mid-cycle
	always @(negedge PCLK)
	begin
		if (rst)
			in_xfer = 1'b0;
		else
		begin
			if (psel && !penable)
			begin
				// Setup cycle T puts completion in T+1+N
				ready_cyc = cyc + 1 + int'(model_wait);
				in_xfer   = 1'b1;
				assert (!pready)
				else
				begin
					$display("Error %s: pready in setup cycle expected 0 actual 1", test_name);
					count_error();
				end
			end
			else if (psel && penable && in_xfer)
			begin
				exp_ready = (cyc == ready_cyc);
				assert (pready == exp_ready)
				else
				begin
					$display("Error %s: pready in cycle %0d expected %0b actual %0b",
						test_name, cyc, exp_ready, pready);
					count_error();
				end
				if (pready)
					in_xfer = 1'b0;
			end
			else if (!psel)
			begin
				in_xfer = 1'b0;
				assert (!pready)
				else
				begin
					$display("Error %s: pready without psel expected 0 actual 1", test_name);
					count_error();
				end
			end
			// Error response only in a completing cycle
			assert (!pslverr || (psel && penable && pready))
			else
			begin
				$display("%s: pslverr raised outside a completing cycle", test_name);
				count_error();
			end
			if (psel && penable && pready)
			begin
				exp_err = expect_err(paddr, pwrite, pprot, pwstrb);
				assert (pslverr == exp_err)
				else
				begin
					$display("Error %s: pslverr at %h expected %0b actual %0b",
						test_name, paddr, exp_err, pslverr);
					count_error();
				end
			end
		end
	end

	//////////////////////////////
	// APB driver
	//////////////////////////////

	task automatic next_cycle();
		@(posedge PCLK);
		#(DRIVE_DELAY);
	endtask

	task automatic drive_setup(input logic [ADDR_W-1:0] addr, input logic write,
		input logic [31:0] data, input logic [3:0] strb, input logic [2:0] prot);
		next_cycle();
		psel    = 1'b1;
		penable = 1'b0;
		paddr   = addr;
		pwrite  = write;
		pwdata  = data;
		pwstrb  = strb;
		pprot   = prot;
	endtask

	// Waits in the access phase for pready and then returns the bus to idle
	task automatic finish_xfer(output logic [31:0] rdata, output logic err, output int acc);
		logic got;
		got   = 1'b0;
		acc   = 0;
		rdata = '0;
		err   = 1'b0;
		while (!got && acc < XFER_TIMEOUT)
		begin
			@(negedge PCLK);
			acc++;
			if (pready)
			begin
				got   = 1'b1;
				rdata = prdata;
				err   = pslverr;
			end
		end
		if (!got)
		begin
			$display("%s: no pready within %0d access cycles, transfer abandoned",
				test_name, XFER_TIMEOUT);
			count_error();
		end
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_xfer(input logic [ADDR_W-1:0] addr, input logic write,
		input logic [31:0] data, input logic [3:0] strb, input logic [2:0] prot,
		output logic [31:0] rdata, output logic err, output int acc);
		drive_setup(addr, write, data, strb, prot);
		next_cycle();
		penable = 1'b1;
		finish_xfer(rdata, err, acc);
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [2:0] prot, output logic err);
		logic [31:0] rd;
		int          acc;
		apb_xfer(addr, 1'b1, data, strb, prot, rd, err, acc);
		model_write(addr, data, strb, prot);
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic [2:0] prot,
		output logic [31:0] rdata, output logic err, output int acc);
		apb_xfer(addr, 1'b0, 32'h0, 4'h0, prot, rdata, err, acc);
	endtask

	task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [2:0] prot);
		logic [31:0] rd;
		logic        err;
		int          acc;
		apb_read(addr, prot, rd, err, acc);
		check_value($sformatf("read data at %h", addr), model_read(addr), rd);
	endtask

	// Privileged write of the wait count
	task automatic set_wait(input int n);
		logic err;
		apb_write(ADDR_W'(apb_pkg::ADDR_WAIT_CFG), 32'(n), 4'hF, 3'b001, err);
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////
	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge PCLK);
		$display("Watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial
	begin
		logic [31:0]               rd;
		logic                      err;
		int                        acc;
		int                        n;
		logic [ADDR_W-1:0]         addr;
		logic [2:0]                prot;
		logic [apb_pkg::VIO_W-1:0] exp_vio;

		void'($urandom(RAND_SEED));
		psel         = 1'b0;
		penable      = 1'b0;
		paddr        = '0;
		pwrite       = 1'b0;
		pwdata       = '0;
		pwstrb       = '0;
		pprot        = '0;
		in_xfer      = 1'b0;
		ready_cyc    = 0;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		model_wait   = '0;
		for (int i = 0; i < 4; i++)
			model_data[i] = '0;

		@(negedge rst);
		next_cycle();

		// Full then partial strobes on every data register
		start_test("data_readback");
		for (int i = 0; i < 4; i++)
			apb_write(data_addr(i), $urandom(), 4'hF, 3'b000, err);
		for (int i = 0; i < 4; i++)
			read_check(data_addr(i), 3'b000);
		for (int i = 0; i < 4; i++)
		begin
			apb_write(data_addr(i), $urandom(), PART_STRB[i], 3'b010, err);
			read_check(data_addr(i), 3'b000);
		end
		check_value("violations", 32'h0, 32'(violations));
		end_test();

		// pready in cycle T+1+N for N of 0, 2 and 3
		start_test("wait_states");
		for (int k = 0; k < 3; k++)
		begin
			n = (k == 0) ? 0 : k + 1;
			set_wait(n);
			apb_read(data_addr(1), 3'b000, rd, err, acc);
			check_value($sformatf("access cycles at wait %0d", n), 32'(n + 1), 32'(acc));
			check_value("read data", model_read(data_addr(1)), rd);
		end
		set_wait(1);
		end_test();

		// Error responses that change nothing
		start_test("slave_errors");
		apb_read(ADDR_W'(12'h018), 3'b001, rd, err, acc);
		check_value("pslverr on unmapped read", 32'h1, 32'(err));
		apb_write(ADDR_W'(12'h020), $urandom(), 4'hF, 3'b001, err);
		check_value("pslverr on unmapped write", 32'h1, 32'(err));
		apb_write(ADDR_W'(12'hFFC), $urandom(), 4'hF, 3'b001, err);
		check_value("pslverr on top address write", 32'h1, 32'(err));
		apb_write(ADDR_W'(apb_pkg::ADDR_WAIT_CFG), 32'h5, 4'hF, 3'b000, err);
		check_value("pslverr on user config write", 32'h1, 32'(err));
		read_check(ADDR_W'(apb_pkg::ADDR_WAIT_CFG), 3'b000);
		for (int i = 0; i < 4; i++)
			read_check(data_addr(i), 3'b000);
		check_value("violations", 32'h0, 32'(violations));
		end_test();

		// Master breaches seen by the monitor
		start_test("protocol_breach");
		set_wait(2);
		// Abandon a read after one access cycle
		drive_setup(data_addr(0), 1'b0, 32'h0, 4'h0, 3'b000);
		next_cycle();
		penable = 1'b1;
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
		next_cycle();
		exp_vio = '0;
		exp_vio[apb_pkg::VIO_PSEL_DROP] = 1'b1;
		check_value("violations after psel drop", 32'(exp_vio), 32'(violations));
		// Move the address while waiting
		drive_setup(data_addr(1), 1'b0, 32'h0, 4'h0, 3'b000);
		next_cycle();
		penable = 1'b1;
		next_cycle();
		paddr = data_addr(2);
		finish_xfer(rd, err, acc);
		check_value("read data after move", model_read(data_addr(2)), rd);
		exp_vio[apb_pkg::VIO_UNSTABLE] = 1'b1;
		check_value("violations after address change", 32'(exp_vio), 32'(violations));
		apb_read(ADDR_W'(apb_pkg::ADDR_STATUS), 3'b000, rd, err, acc);
		check_value("status read", 32'(exp_vio), rd);
		apb_write(ADDR_W'(apb_pkg::ADDR_STATUS), 32'h0, 4'hF, 3'b000, err);
		check_value("violations after clear", 32'h0, 32'(violations));
		set_wait(0);
		end_test();

		// Six waits exceed the stall limit of four
		start_test("stall_limit");
		set_wait(6);
		apb_read(data_addr(0), 3'b000, rd, err, acc);
		check_value("access cycles at wait 6", 32'd7, 32'(acc));
		exp_vio = '0;
		exp_vio[apb_pkg::VIO_STALL] = 1'b1;
		check_value("violations after stall", 32'(exp_vio), 32'(violations));
		apb_read(ADDR_W'(apb_pkg::ADDR_STATUS), 3'b000, rd, err, acc);
		check_value("status read", 32'(exp_vio), rd);
		set_wait(0);
		apb_write(ADDR_W'(apb_pkg::ADDR_STATUS), 32'h0, 4'hF, 3'b000, err);
		check_value("violations after clear", 32'h0, 32'(violations));
		end_test();

		// Random legal traffic with a new wait count every 8 transfers
		start_test("random_traffic");
		for (int i = 0; i < 200; i++)
		begin
			if (i % 8 == 0)
				set_wait(int'($urandom_range(3, 0)));
			addr = data_addr(int'($urandom_range(3, 0)));
			prot = 3'($urandom_range(7, 0));
			if ($urandom_range(1, 0) == 1)
				apb_write(addr, $urandom(), 4'($urandom_range(15, 0)), prot, err);
			else
				read_check(addr, prot);
		end
		for (int i = 0; i < 4; i++)
			read_check(data_addr(i), 3'b000);
		check_value("violations", 32'h0, 32'(violations));
		end_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
/*
 * Clock and reset source for the APB slave testbench.
 * PCLK runs freely from time zero. rst is held high for a fixed number
 * of rising edges and released a short delay after the last one.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 4,
	parameter int DRIVE_DELAY  = 5
)
(
	output logic PCLK,
	output logic rst
);

	// Free running clock, low first
	initial
	begin
		PCLK = 1'b0;
		forever
			#(PERIOD / 2) PCLK = ~PCLK;
	end

	// Synchronous reset, released like any other driven input
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge PCLK);
		#(DRIVE_DELAY);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* source/apb_regbank_top.sv */
/*
 * APB3 register slave with programmable wait states.
 * Joins the access FSM, the wait timer, the register bank and the
 * protocol monitor. The external master drives the APB inputs.
 */
`timescale 1ns/1ns
`default_nettype none

module apb_regbank_top #(
	parameter int ADDR_W    = 12,
	parameter int MAX_STALL = 4
)
(
	input  wire                       PCLK,
	input  wire                       rst,
	input  wire                       psel,
	input  wire                       penable,
	input  wire [ADDR_W-1:0]          paddr,
	input  wire                       pwrite,
	input  wire [31:0]                pwdata,
	input  wire [3:0]                 pwstrb,
	input  wire [2:0]                 pprot,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	output logic [apb_pkg::VIO_W-1:0] violations
);

	// FSM to timer
	logic                       timer_load;
	logic                       timer_done;
	// FSM to register bank
	logic                       op_strobe;
	apb_pkg::reg_op_t           op;
	// Register bank to timer and monitor
	logic [apb_pkg::WAIT_W-1:0] wait_count;
	logic                       status_clear;

	apb_access_fsm u_fsm (
		.PCLK       (PCLK),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.timer_done (timer_done),
		.timer_load (timer_load),
		.pready     (pready),
		.op_strobe  (op_strobe),
		.op         (op)
	);

	wait_timer u_timer (
		.PCLK       (PCLK),
		.rst        (rst),
		.load       (timer_load),
		.wait_count (wait_count),
		.done       (timer_done)
	);

	reg_bank #(.ADDR_W(ADDR_W)) u_regs (
		.PCLK         (PCLK),
		.rst          (rst),
		.op_strobe    (op_strobe),
		.pwrite       (pwrite),
		.pprot        (pprot),
		.op           (op),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.pwstrb       (pwstrb),
		.violations   (violations),
		.prdata       (prdata),
		.pslverr      (pslverr),
		.wait_count   (wait_count),
		.status_clear (status_clear)
	);

	// Watches the same port the master sees
	apb_protocol_monitor #(.ADDR_W(ADDR_W), .MAX_STALL(MAX_STALL)) u_mon (
		.PCLK       (PCLK),
		.rst        (rst),
		.psel       (psel),
		.penable    (penable),
		.pready     (pready),
		.pwrite     (pwrite),
		.pslverr    (pslverr),
		.clear      (status_clear),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pwstrb     (pwstrb),
		.pprot      (pprot),
		.violations (violations)
	);

endmodule

`default_nettype wire

/* source/apb_protocol_monitor.sv */
/*
 * Passive APB3 bus watcher for one slave port.
 * Compares the bus with its previous-cycle copy and latches each rule
 * breach, by master or slave, into a sticky violation bit.
 * clear wipes the flags; a breach in the same cycle still sets its bit.
 */
`timescale 1ns/1ns
`default_nettype none

module apb_protocol_monitor #(
	parameter int ADDR_W    = 12,
	parameter int MAX_STALL = 4
)
(
	input  wire                       PCLK,
	input  wire                       rst,
	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pready,
	input  wire                       pwrite,
	input  wire                       pslverr,
	input  wire                       clear,
	input  wire [ADDR_W-1:0]          paddr,
	input  wire [31:0]                pwdata,
	input  wire [3:0]                 pwstrb,
	input  wire [2:0]                 pprot,
	output logic [apb_pkg::VIO_W-1:0] violations
);

	localparam int CNT_W = $clog2(MAX_STALL + 1);

	// Previous cycle view of the bus
	logic              psel_q;
	logic              penable_q;
	logic              pready_q;
	logic [ADDR_W-1:0] paddr_q;
	logic              pwrite_q;
	logic [31:0]       pwdata_q;
	logic [3:0]        pwstrb_q;
	logic [2:0]        pprot_q;

	logic [CNT_W-1:0]          stall_cnt;
	logic                      pending_q;
	logic [apb_pkg::VIO_W-1:0] hit;

	// Last cycle belonged to a transfer that had not completed
	assign pending_q = psel_q && !(penable_q && pready_q);

	//////////////////////////////
	// Rule checks
	//////////////////////////////
	always_comb
	begin
		hit = '0;
		// Master deselects before pready
		hit[apb_pkg::VIO_PSEL_DROP] = pending_q && !psel;
		// penable sequencing
		if (psel)
		begin
			if (!psel_q)
				hit[apb_pkg::VIO_PENABLE] = penable;
			else if (penable_q)
				// Must hold while stalled and fall after completion
				hit[apb_pkg::VIO_PENABLE] = (penable != !pready_q);
			else
				hit[apb_pkg::VIO_PENABLE] = !penable;
		end
		else
			// penable must also fall when the master deselects after completion
			hit[apb_pkg::VIO_PENABLE] = penable && psel_q && penable_q && pready_q;
		// Address, control and write data hold until completion
		hit[apb_pkg::VIO_UNSTABLE] = pending_q && psel
			&& ((paddr != paddr_q) || (pwrite != pwrite_q) || (pprot != pprot_q)
			|| (pwrite && ((pwdata != pwdata_q) || (pwstrb != pwstrb_q))));
		hit[apb_pkg::VIO_STALL] = (stall_cnt >= CNT_W'(MAX_STALL));
		// Slave error outside the completing cycle
		hit[apb_pkg::VIO_SLVERR] = pslverr && !(psel && penable && pready);
	end

	//////////////////////////////
	// History and stall counter
	//////////////////////////////
	always_ff @(posedge PCLK)
	begin
		paddr_q  <= paddr;
		pwrite_q <= pwrite;
		pwdata_q <= pwdata;
		pwstrb_q <= pwstrb;
		pprot_q  <= pprot;
		if (rst)
		begin
			psel_q    <= 1'b0;
			penable_q <= 1'b0;
			pready_q  <= 1'b0;
			stall_cnt <= '0;
		end
		else
		begin
			psel_q    <= psel;
			penable_q <= penable;
			pready_q  <= pready;
			// Counts access cycles with pready low and saturates
			if (!psel || !penable || pready)
				stall_cnt <= '0;
			else if (stall_cnt < CNT_W'(MAX_STALL))
				stall_cnt <= stall_cnt + 1'b1;
		end
	end

	// Sticky flags
	always_ff @(posedge PCLK)
	begin
		if (rst)
			violations <= '0;
		else
			violations <= (clear ? '0 : violations) | hit;
	end

endmodule

`default_nettype wire

/* source/reg_bank.sv */
/*
 * Register bank of the APB slave.
 * Four byte-strobed data registers, the wait configuration register and
 * the read-only status register holding the monitor flags.
 * Read data and error decode are combinational; writes commit on the
 * operation strobe at the end of the completing cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module reg_bank #(
	parameter int ADDR_W = 12
)
(
	input  wire                        PCLK,
	input  wire                        rst,
	input  wire                        op_strobe,
	input  wire                        pwrite,
	input  wire [2:0]                  pprot,
	input  wire apb_pkg::reg_op_t      op,
	input  wire [ADDR_W-1:0]           paddr,
	input  wire [31:0]                 pwdata,
	input  wire [3:0]                  pwstrb,
	input  wire [apb_pkg::VIO_W-1:0]   violations,
	output logic [31:0]                prdata,
	output logic                       pslverr,
	output logic [apb_pkg::WAIT_W-1:0] wait_count,
	output logic                       status_clear
);

	logic [31:0] data_q [4];
	logic        hit_data;
	logic [1:0]  data_idx;
	logic        hit_cfg;
	logic        hit_status;
	logic        err;
	logic        wr_ok;

	//////////////////////////////
	// Address decode
	//////////////////////////////
	always_comb
	begin
		hit_data   = 1'b0;
		data_idx   = 2'd0;
		hit_cfg    = 1'b0;
		hit_status = 1'b0;
		case (paddr)
			ADDR_W'(apb_pkg::ADDR_DATA0):
			begin
				hit_data = 1'b1;
				data_idx = 2'd0;
			end
			ADDR_W'(apb_pkg::ADDR_DATA1):
			begin
				hit_data = 1'b1;
				data_idx = 2'd1;
			end
			ADDR_W'(apb_pkg::ADDR_DATA2):
			begin
				hit_data = 1'b1;
				data_idx = 2'd2;
			end
			ADDR_W'(apb_pkg::ADDR_DATA3):
			begin
				hit_data = 1'b1;
				data_idx = 2'd3;
			end
			ADDR_W'(apb_pkg::ADDR_WAIT_CFG): hit_cfg = 1'b1;
			ADDR_W'(apb_pkg::ADDR_STATUS):   hit_status = 1'b1;
			default: ;
		endcase
	end

	// Unmapped, status write without the flag byte, or user write to config
	assign err = !(hit_data || hit_cfg || hit_status)
		|| (pwrite && hit_status && !pwstrb[0])
		|| (pwrite && hit_cfg && !pprot[0]);

	// Error only shows in the completing cycle
	assign pslverr = op_strobe && err;

	assign wr_ok        = op_strobe && (op == apb_pkg::OP_WRITE) && !err;
	assign status_clear = wr_ok && hit_status;

	//////////////////////////////
	// Read mux
	//////////////////////////////
	always_comb
	begin
		prdata = '0;
		if (hit_data)
			prdata = data_q[data_idx];
		else if (hit_cfg)
			prdata = 32'(wait_count);
		else if (hit_status)
			// Flags zero-extended
			prdata = 32'(violations);
	end

	//////////////////////////////
	// Register updates
	//////////////////////////////
	always_ff @(posedge PCLK)
	begin
		if (rst)
		begin
			for (int i = 0; i < 4; i++)
				data_q[i] <= '0;
			wait_count <= '0;
		end
		else if (wr_ok)
		begin
			// Merge only the strobed bytes
			if (hit_data)
				for (int b = 0; b < 4; b++)
					if (pwstrb[b])
						data_q[data_idx][8*b +: 8] <= pwdata[8*b +: 8];
			if (hit_cfg && pwstrb[0])
				wait_count <= pwdata[apb_pkg::WAIT_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* source/wait_timer.sv */
/*
 * Wait state counter for the access phase.
 * Loads the configured count on the setup strobe and counts down once
 * per cycle. done stays high while the count is zero.
 */
`timescale 1ns/1ns
`default_nettype none

module wait_timer
(
	input  wire                        PCLK,
	input  wire                        rst,
	input  wire                        load,
	input  wire [apb_pkg::WAIT_W-1:0]  wait_count,
	output logic                       done
);

	// Remaining wait cycles
	logic [apb_pkg::WAIT_W-1:0] count;

	always_ff @(posedge PCLK)
	begin
		if (rst)
			count <= '0;
		else if (load)
			// Sample the configured count in the setup cycle
			count <= wait_count;
		else if (count != '0)
			count <= count - 1'b1;
	end

	// First access cycle sees the loaded value
	assign done = (count == '0);

endmodule

`default_nettype wire

/* source/apb_access_fsm.sv */
/*
 * Slave side state machine for APB3 transfers.
 * Starts the wait timer in the setup cycle, holds pready low until the
 * timer expires and then completes the transfer with a one-cycle
 * operation strobe to the register bank.
 */
`timescale 1ns/1ns
`default_nettype none

module apb_access_fsm
(
	input  wire              PCLK,
	input  wire              rst,
	input  wire              psel,
	input  wire              penable,
	input  wire              pwrite,
	input  wire              timer_done,
	output logic             timer_load,
	output logic             pready,
	output logic             op_strobe,
	output apb_pkg::reg_op_t op
);

	apb_pkg::access_state_t state;
	apb_pkg::access_state_t state_next;
	// Setup cycle on the bus
	logic setup_seen;
	// Completing cycle of the current transfer
	logic complete;

	assign setup_seen = psel && !penable;

	//////////////////////////////
	// Next state and strobes
	//////////////////////////////
	always_comb
	begin
		state_next = state;
		timer_load = 1'b0;
		complete   = 1'b0;
		case (state)
			// Idle, or the cycle right after a completion
			apb_pkg::ACC_IDLE, apb_pkg::ACC_READY:
			begin
				if (setup_seen)
				begin
					timer_load = 1'b1;
					state_next = apb_pkg::ACC_SETUP;
				end
				else
					state_next = apb_pkg::ACC_IDLE;
			end
			// First access cycle after setup, or a later wait cycle
			apb_pkg::ACC_SETUP, apb_pkg::ACC_WAIT:
			begin
				if (!psel)
					// Master gave up, no strobe
					state_next = apb_pkg::ACC_IDLE;
				else if (penable && timer_done)
				begin
					complete   = 1'b1;
					state_next = apb_pkg::ACC_READY;
				end
				else
					state_next = apb_pkg::ACC_WAIT;
			end
			default:
				state_next = apb_pkg::ACC_IDLE;
		endcase
	end

	// Ready, strobe and direction share the completing cycle
	assign pready    = complete;
	assign op_strobe = complete;
	assign op        = !complete ? apb_pkg::OP_NONE :
		(pwrite ? apb_pkg::OP_WRITE : apb_pkg::OP_READ);

	always_ff @(posedge PCLK)
	begin
		if (rst)
			state <= apb_pkg::ACC_IDLE;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

/* source/apb_pkg.sv */
/*
 * Shared definitions for the APB3 register slave and its bus monitor.
 * Holds the access FSM states, the register operation opcodes, the
 * register map and the bit layout of the violation vector.
 * Modules refer to these by scoped names.
 */
`default_nettype none

package apb_pkg;

	//////////////////////////////
	// Access FSM and operations
	//////////////////////////////

	// Phases of an APB transfer as seen by the slave
	typedef enum logic [1:0]
	{
		ACC_IDLE  = 2'd0,
		ACC_SETUP = 2'd1,
		ACC_WAIT  = 2'd2,
		ACC_READY = 2'd3
	} access_state_t;

	// Opcode issued with the operation strobe
	typedef enum logic [1:0]
	{
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} reg_op_t;

	//////////////////////////////
	// Register map
	//////////////////////////////

	// Byte offsets of the data registers
	localparam logic [11:0] ADDR_DATA0    = 12'h000;
	localparam logic [11:0] ADDR_DATA1    = 12'h004;
	localparam logic [11:0] ADDR_DATA2    = 12'h008;
	localparam logic [11:0] ADDR_DATA3    = 12'h00C;
	// Wait count in the low bits, privileged writes only
	localparam logic [11:0] ADDR_WAIT_CFG = 12'h010;
	// Violation flags, a write clears them
	localparam logic [11:0] ADDR_STATUS   = 12'h014;

	// Width of the wait count field
	localparam int WAIT_W = 3;

	//////////////////////////////
	// Violation vector
	//////////////////////////////

	localparam int VIO_W         = 5;
	localparam int VIO_PSEL_DROP = 0;
	localparam int VIO_PENABLE   = 1;
	localparam int VIO_UNSTABLE  = 2;
	localparam int VIO_STALL     = 3;
	localparam int VIO_SLVERR    = 4;

endpackage

`default_nettype wire
